/* rtl/mmio_cfg.svh */
`ifndef MMIO_CFG_SVH
`define MMIO_CFG_SVH

// ------------------------------
// bus widths
// ------------------------------
`define MMIO_ADDR_BITS      32
`define MMIO_DATA_BITS      32

// ------------------------------
// address map
// ------------------------------
`define ADDR_CYCLE_CNT      32'h8000_0010
`define ADDR_INSTR_CNT      32'h8000_0014
`define ADDR_CNT_CLEAR      32'h8000_0018   // store clears both counters
`define ADDR_BTN_EMPTY      32'h8000_0020
`define ADDR_BTN_POP        32'h8000_0024   // load pops the button fifo
`define ADDR_SWITCHES       32'h8000_0028
`define ADDR_LEDS           32'h8000_0030
`define ADDR_TONE_EN        32'h8000_0034
`define ADDR_TONE_PERIOD    32'h8000_0038
`define ADDR_I2S_FULL       32'h8000_0040
`define ADDR_I2S_SAMPLE     32'h8000_0044

// ------------------------------
// board io
// ------------------------------
`define BUTTON_BITS         4
`define SWITCH_BITS         2
`define BTN_FIFO_DEPTH      32
`define LED_BOARD_BITS      6
`define LED_PMOD_BITS       8
`define LED_PMOD_LSB        8               // pmod byte sits in wdata[15:8]
`define TONE_PERIOD_BITS    24
`define TONE_PERIOD_RESET   24'h555
`define SAMPLE_BITS         24

`endif

/* rtl/bus_pkg.sv */
`include "mmio_cfg.svh"

package bus_pkg;

    // one access from the execute stage, a plain strobe
    typedef struct packed {
        logic                       valid;
        logic                       write;  // high for store, low for load
        logic [`MMIO_ADDR_BITS-1:0] addr;
        logic [`MMIO_DATA_BITS-1:0] wdata;
    } mmio_req_t;

    // combinational read result of one unit
    typedef struct packed {
        logic                       hit;    // load hit one of the unit's addresses
        logic [`MMIO_DATA_BITS-1:0] data;
    } unit_rd_t;

    // load data, one cycle after the request
    typedef struct packed {
        logic                       valid;
        logic [`MMIO_DATA_BITS-1:0] data;
    } mmio_rsp_t;

endpackage

/* rtl/periph_pkg.sv */
`include "mmio_cfg.svh"

package periph_pkg;

    // board and pmod led banks
    typedef struct packed {
        logic [`LED_BOARD_BITS-1:0] board;
        logic [`LED_PMOD_BITS-1:0]  pmod;
    } led_state_t;

    // square wave tone generator controls
    typedef struct packed {
        logic                         enable;
        logic [`TONE_PERIOD_BITS-1:0] period;   // half period in clocks
    } tone_ctrl_t;

    // write side of the i2s async fifo
    typedef struct packed {
        logic                    valid;         // one cycle per pushed sample
        logic [`SAMPLE_BITS-1:0] data;
    } sample_push_t;

endpackage

/* rtl/button_fifo.sv */
`timescale 1ns/10ps
`include "mmio_cfg.svh"

module button_fifo (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_en,
    input  logic [`BUTTON_BITS-1:0] din,
    input  logic                    rd_en,
    output logic [`BUTTON_BITS-1:0] dout,
    output logic                    full,
    output logic                    empty
);

    localparam int DEPTH    = `BTN_FIFO_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = PTR_BITS + 1;

    logic [`BUTTON_BITS-1:0] mem [DEPTH];
    logic [PTR_BITS-1:0]     wr_ptr;
    logic [PTR_BITS-1:0]     rd_ptr;
    logic [CNT_BITS-1:0]     count;
    logic                    do_wr;
    logic                    do_rd;

    assign do_wr = wr_en && (count != CNT_BITS'(DEPTH));
    assign do_rd = rd_en && !empty;     // pop on empty is dropped

    assign empty = (count == '0);
    // full also covers a write already in flight, so the capture
    // stage upstream never has a snapshot with nowhere to go
    assign full  = (count == CNT_BITS'(DEPTH)) ||
                   (count == CNT_BITS'(DEPTH - 1) && wr_en);

    assign dout  = mem[rd_ptr];         // show-ahead head

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // capture logic in board_io_regs must hold off before the buffer fills
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> count != CNT_BITS'(DEPTH))
        else $error("button fifo written while full");

    // read pointer never runs past the write pointer, even on an ignored pop
    a_ptr_count_agree: assert property (@(posedge clk) disable iff (rst)
        (int'(rd_ptr) + int'(count)) % DEPTH == int'(wr_ptr))
        else $error("button fifo pointers and count disagree");

endmodule

/* rtl/board_io_regs.sv */
`timescale 1ns/10ps
`include "mmio_cfg.svh"

module board_io_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  bus_pkg::mmio_req_t       req,
    input  logic [`BUTTON_BITS-1:0]  buttons,
    input  logic [`SWITCH_BITS-1:0]  switches,
    input  logic                     async_fifo_full,
    output periph_pkg::led_state_t   leds,
    output periph_pkg::tone_ctrl_t   tone,
    output periph_pkg::sample_push_t sample,
    output bus_pkg::unit_rd_t        io_rd
);

    logic                    is_store;
    logic                    is_load;
    logic                    sample_wr;
    logic                    btn_pop;
    logic                    cap_valid;     // snapshot waiting for the fifo
    logic [`BUTTON_BITS-1:0] cap_data;
    logic [`BUTTON_BITS-1:0] fifo_dout;
    logic                    fifo_full;
    logic                    fifo_empty;

    assign is_store  = req.valid && req.write;
    assign is_load   = req.valid && !req.write;
    assign sample_wr = is_store && (req.addr == `ADDR_I2S_SAMPLE);
    assign btn_pop   = is_load && (req.addr == `ADDR_BTN_POP);

    // ------------------------------
    // store decode
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            leds         <= '0;
            tone.enable  <= 1'b0;
            tone.period  <= `TONE_PERIOD_RESET;
            sample.valid <= 1'b0;
        end else begin
            if (is_store && req.addr == `ADDR_LEDS) begin
                leds.board <= req.wdata[`LED_BOARD_BITS-1:0];
                leds.pmod  <= req.wdata[`LED_PMOD_LSB +: `LED_PMOD_BITS];
            end
            if (is_store && req.addr == `ADDR_TONE_EN) begin
                tone.enable <= req.wdata[0];
            end
            if (is_store && req.addr == `ADDR_TONE_PERIOD) begin
                tone.period <= req.wdata[`TONE_PERIOD_BITS-1:0];
            end
            sample.valid <= sample_wr;      // pushed regardless of async fifo full
        end
        if (sample_wr) begin
            sample.data <= req.wdata[`SAMPLE_BITS-1:0];
        end
    end

    // ------------------------------
    // button capture
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= (|buttons) && !fifo_full;
        end
        cap_data <= buttons;
    end

    button_fifo u_button_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (cap_valid),
        .din   (cap_data),
        .rd_en (btn_pop),
        .dout  (fifo_dout),
        .full  (fifo_full),
        .empty (fifo_empty)
    );

    // load side, values zero-extended
    always_comb begin
        io_rd = '0;
        if (is_load) begin
            case (req.addr)
                `ADDR_BTN_EMPTY: begin
                    io_rd.hit     = 1'b1;
                    io_rd.data[0] = fifo_empty;
                end
                `ADDR_BTN_POP: begin
                    io_rd.hit                       = 1'b1;
                    io_rd.data[`BUTTON_BITS-1:0]    = fifo_dout;  // stale head if empty
                end
                `ADDR_SWITCHES: begin
                    io_rd.hit                       = 1'b1;
                    io_rd.data[`SWITCH_BITS-1:0]    = switches;
                end
                `ADDR_I2S_FULL: begin
                    io_rd.hit     = 1'b1;
                    io_rd.data[0] = async_fifo_full;
                end
                default: io_rd = '0;
            endcase
        end
    end

endmodule

/* rtl/perf_counters.sv */
`timescale 1ns/10ps
`include "mmio_cfg.svh"

module perf_counters (
    input  logic               clk,
    input  logic               rst,
    input  bus_pkg::mmio_req_t req,
    input  logic               retire,
    output bus_pkg::unit_rd_t  cnt_rd
);

    logic [`MMIO_DATA_BITS-1:0] cycle_cnt;
    logic [`MMIO_DATA_BITS-1:0] instr_cnt;
    logic                       is_load;
    logic                       clear;

    assign is_load = req.valid && !req.write;
    assign clear   = req.valid && req.write && (req.addr == `ADDR_CNT_CLEAR);

    // clear wins over the increment
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cycle_cnt <= '0;
            instr_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (retire) begin
                instr_cnt <= instr_cnt + 1'b1;
            end
        end
    end

    // reads see the count held before the edge
    always_comb begin
        cnt_rd = '0;
        if (is_load && req.addr == `ADDR_CYCLE_CNT) begin
            cnt_rd.hit  = 1'b1;
            cnt_rd.data = cycle_cnt;
        end else if (is_load && req.addr == `ADDR_INSTR_CNT) begin
            cnt_rd.hit  = 1'b1;
            cnt_rd.data = instr_cnt;
        end
    end

endmodule

/* rtl/load_return.sv */
`timescale 1ns/10ps

module load_return (
    input  logic               clk,
    input  logic               rst,
    input  bus_pkg::mmio_req_t req,
    input  bus_pkg::unit_rd_t  io_rd,
    input  bus_pkg::unit_rd_t  cnt_rd,
    output bus_pkg::mmio_rsp_t rsp
);

    import bus_pkg::*;

    mmio_rsp_t rsp_d;

    // pick whichever unit claimed the load, unmapped reads return zero
    always_comb begin
        rsp_d.valid = req.valid && !req.write;
        if (io_rd.hit) begin
            rsp_d.data = io_rd.data;
        end else if (cnt_rd.hit) begin
            rsp_d.data = cnt_rd.data;
        end else begin
            rsp_d.data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= rsp_d.valid;
        end
        rsp.data <= rsp_d.data;     // only meaningful with valid
    end

    // address maps of the two units must not overlap
    a_hits_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(io_rd.hit && cnt_rd.hit))
        else $error("both units claimed the same load");

    // a unit only claims loads, never stores or idle cycles
    a_hit_needs_load: assert property (@(posedge clk) disable iff (rst)
        (io_rd.hit || cnt_rd.hit) |-> (req.valid && !req.write))
        else $error("read hit without a load");

endmodule

/* rtl/mmio_hub.sv */
`timescale 1ns/10ps
`include "mmio_cfg.svh"

module mmio_hub (
    input  logic                     clk,
    input  logic                     rst,
    input  bus_pkg::mmio_req_t       req,
    input  logic                     retire,
    input  logic [`BUTTON_BITS-1:0]  buttons,
    input  logic [`SWITCH_BITS-1:0]  switches,
    input  logic                     async_fifo_full,
    output bus_pkg::mmio_rsp_t       rsp,
    output periph_pkg::led_state_t   leds,
    output periph_pkg::tone_ctrl_t   tone,
    output periph_pkg::sample_push_t sample
);

    import bus_pkg::*;

    unit_rd_t io_rd;    // board io read result
    unit_rd_t cnt_rd;   // counter read result

    board_io_regs u_board_io_regs (
        .clk             (clk),
        .rst             (rst),
        .req             (req),
        .buttons         (buttons),
        .switches        (switches),
        .async_fifo_full (async_fifo_full),
        .leds            (leds),
        .tone            (tone),
        .sample          (sample),
        .io_rd           (io_rd)
    );

    perf_counters u_perf_counters (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .retire (retire),
        .cnt_rd (cnt_rd)
    );

    // one registered response per load
    load_return u_load_return (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .io_rd  (io_rd),
        .cnt_rd (cnt_rd),
        .rsp    (rsp)
    );

endmodule

/* verif/tb_mmio_hub.sv */
`timescale 1ns/10ps
`include "mmio_cfg.svh"

module tb_mmio_hub;

    import bus_pkg::*;
    import periph_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 10;
    localparam int N_REG_OPS       = 300;
    localparam int N_SAMPLE_OPS    = 200;
    localparam int BTN_ROUNDS      = 8;
    localparam int BTN_ROUND_MAX   = 48;    // 20 held, 3 drain, 20 pops, reads
    localparam int N_CNT_OPS       = 300;
    localparam int N_UNMAPPED      = 100;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + 10 + N_REG_OPS + N_SAMPLE_OPS
                                   + BTN_ROUNDS * BTN_ROUND_MAX + N_CNT_OPS + N_UNMAPPED;
    localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 200;

    logic         clk;
    logic         rst;
    mmio_req_t    req;
    logic         retire;
    logic [3:0]   buttons;
    logic [1:0]   switches;
    logic         async_fifo_full;
    mmio_rsp_t    rsp;
    led_state_t   leds;
    tone_ctrl_t   tone;
    sample_push_t sample;

    // ------------------------------
    // reference model state
    // ------------------------------
    led_state_t  m_leds;
    tone_ctrl_t  m_tone;
    logic        m_sample_valid;
    logic [23:0] m_sample_data;
    logic [31:0] m_cycles;
    logic [31:0] m_instrs;
    logic [3:0]  m_btn_q [$];       // snapshots in the fifo
    logic        m_cap_valid;
    logic [3:0]  m_cap_data;
    logic        m_rsp_valid;
    logic        m_rsp_care;        // low for a pop of an empty fifo
    logic [31:0] m_rsp_data;

    // inputs the dut samples at the coming edge
    mmio_req_t   p_req;
    logic        p_retire;
    logic [3:0]  p_buttons;
    logic [1:0]  p_switches;
    logic        p_full;

    // board inputs to drive with the next request
    logic [3:0]  drv_buttons;
    logic [1:0]  drv_switches;
    logic        drv_full;

    integer seed;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;
    string  test_name;

    mmio_hub dut (
        .clk             (clk),
        .rst             (rst),
        .req             (req),
        .retire          (retire),
        .buttons         (buttons),
        .switches        (switches),
        .async_fifo_full (async_fifo_full),
        .rsp             (rsp),
        .leds            (leds),
        .tone            (tone),
        .sample          (sample)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic mmio_req_t make_req(input logic wr, input logic [31:0] addr,
                                           input logic [31:0] data);
        mmio_req_t r;
        r.valid = 1'b1;
        r.write = wr;
        r.addr  = addr;
        r.wdata = data;
        return r;
    endfunction

    // value a load sees before the edge
    function automatic logic [31:0] model_read(input logic [31:0] addr);
        case (addr)
            `ADDR_CYCLE_CNT: return m_cycles;
            `ADDR_INSTR_CNT: return m_instrs;
            `ADDR_BTN_EMPTY: return {31'b0, (m_btn_q.size() == 0)};
            `ADDR_BTN_POP:   return (m_btn_q.size() > 0) ? {28'b0, m_btn_q[0]} : 32'h0;
            `ADDR_SWITCHES:  return {30'b0, p_switches};
            `ADDR_I2S_FULL:  return {31'b0, p_full};
            default:         return 32'h0;
        endcase
    endfunction

    // one rising edge of the model
    task automatic apply_edge();
        logic is_store;
        logic is_load;
        is_store = p_req.valid && p_req.write;
        is_load  = p_req.valid && !p_req.write;
        m_rsp_valid    = is_load;
        m_rsp_care     = !(p_req.addr == `ADDR_BTN_POP && m_btn_q.size() == 0);
        m_rsp_data     = model_read(p_req.addr);
        m_sample_valid = is_store && (p_req.addr == `ADDR_I2S_SAMPLE);
        if (m_sample_valid) begin
            m_sample_data = p_req.wdata[23:0];
        end
        if (is_store && p_req.addr == `ADDR_LEDS) begin
            m_leds.board = p_req.wdata[5:0];
            m_leds.pmod  = p_req.wdata[15:8];
        end
        if (is_store && p_req.addr == `ADDR_TONE_EN) begin
            m_tone.enable = p_req.wdata[0];
        end
        if (is_store && p_req.addr == `ADDR_TONE_PERIOD) begin
            m_tone.period = p_req.wdata[23:0];
        end
        if (is_store && p_req.addr == `ADDR_CNT_CLEAR) begin
            m_cycles = 32'h0;
            m_instrs = 32'h0;
        end else begin
            m_cycles = m_cycles + 32'd1;
            m_instrs = m_instrs + {31'b0, p_retire};
        end
        // pop sees the head before this edge's snapshot lands
        if (is_load && p_req.addr == `ADDR_BTN_POP && m_btn_q.size() > 0) begin
            void'(m_btn_q.pop_front());
        end
        if (m_cap_valid) begin
            m_btn_q.push_back(m_cap_data);
        end
        m_cap_valid = |p_buttons;
        m_cap_data  = p_buttons;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED %s: %s expected %h actual %h at %0t", test_name, what, exp, act, $time);
        test_errors++;
    endtask

    task automatic check_outputs();
        if (rsp.valid !== m_rsp_valid) begin
            report_mismatch("rsp.valid", 32'(m_rsp_valid), 32'(rsp.valid));
        end
        if (m_rsp_valid && m_rsp_care && rsp.data !== m_rsp_data) begin
            report_mismatch("rsp.data", m_rsp_data, rsp.data);
        end
        if (leds !== m_leds) begin
            report_mismatch("leds", 32'(m_leds), 32'(leds));
        end
        if (tone !== m_tone) begin
            report_mismatch("tone", 32'(m_tone), 32'(tone));
        end
        if (sample.valid !== m_sample_valid) begin
            report_mismatch("sample.valid", 32'(m_sample_valid), 32'(sample.valid));
        end
        if (m_sample_valid && sample.data !== m_sample_data) begin
            report_mismatch("sample.data", 32'(m_sample_data), 32'(sample.data));
        end
    endtask

    // drive one request at the edge, check at the falling edge
    task automatic issue(input mmio_req_t r, input logic ret);
        @(posedge clk);
        apply_edge();
        req             <= r;
        retire          <= ret;
        buttons         <= drv_buttons;
        switches        <= drv_switches;
        async_fifo_full <= drv_full;
        p_req      = r;
        p_retire   = ret;
        p_buttons  = drv_buttons;
        p_switches = drv_switches;
        p_full     = drv_full;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic idle(input int n);
        repeat (n) issue('0, 1'b0);
    endtask

    task automatic store(input logic [31:0] addr, input logic [31:0] data);
        issue(make_req(1'b1, addr, data), 1'b0);
    endtask

    task automatic load(input logic [31:0] addr);
        issue(make_req(1'b0, addr, 32'h0), 1'b0);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %-16s done, %0d errors", test_name, test_errors);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int          i;
        int          j;
        int          hold;
        logic [31:0] pick;
        logic [31:0] data;
        seed            = 32'hf252;
        clk             = 1'b0;
        rst             <= 1'b1;
        req             <= '0;
        retire          <= 1'b0;
        buttons         <= '0;
        switches        <= '0;
        async_fifo_full <= 1'b0;
        drv_buttons     = '0;
        drv_switches    = '0;
        drv_full        = 1'b0;
        p_req           = '0;
        p_retire        = 1'b0;
        p_buttons       = '0;
        p_switches      = '0;
        p_full          = 1'b0;
        m_leds          = '0;
        m_tone.enable   = 1'b0;
        m_tone.period   = `TONE_PERIOD_RESET;
        m_sample_valid  = 1'b0;
        m_sample_data   = '0;
        m_cycles        = '0;
        m_instrs        = '0;
        m_cap_valid     = 1'b0;
        m_cap_data      = '0;
        m_rsp_valid     = 1'b0;
        m_rsp_care      = 1'b0;
        m_rsp_data      = '0;
        total_errors    = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // ------------------------------
        // reset and register tests
        // ------------------------------
        begin_test("reset_values");
        idle(2);
        load(`ADDR_CYCLE_CNT);
        load(`ADDR_INSTR_CNT);
        idle(1);
        end_test();

        begin_test("register_stores");
        for (i = 0; i < N_REG_OPS; i++) begin
            pick = $random(seed);
            data = $random(seed);
            case (pick[2:0])
                3'd0, 3'd1: store(`ADDR_LEDS, data);
                3'd2:       store(`ADDR_TONE_EN, data);
                3'd3:       store(`ADDR_TONE_PERIOD, data);
                3'd4:       store(32'h9000_0000 | (pick & 32'h0fff_fff0), data);
                3'd5:       store(`ADDR_BTN_EMPTY, data);   // read-only address
                default:    idle(1);
            endcase
        end
        idle(1);
        end_test();

        begin_test("sample_push");
        for (i = 0; i < N_SAMPLE_OPS; i++) begin
            pick     = $random(seed);
            data     = $random(seed);
            drv_full = pick[8];
            case (pick[1:0])
                2'd0, 2'd1: store(`ADDR_I2S_SAMPLE, data);
                2'd2:       load(`ADDR_I2S_FULL);
                default:    idle(1);
            endcase
        end
        drv_full = 1'b0;
        idle(1);
        end_test();

        // ------------------------------
        // button fifo, counters, unmapped
        // ------------------------------
        begin_test("button_fifo");
        for (i = 0; i < BTN_ROUNDS; i++) begin
            pick = $random(seed);
            hold = 1 + int'(pick[7:0]) % 20;
            for (j = 0; j < hold; j++) begin
                pick         = $random(seed);
                drv_buttons  = (pick[3:0] == 4'h0) ? 4'h1 : pick[3:0];
                drv_switches = pick[5:4];
                idle(1);
            end
            drv_buttons = '0;
            idle(3);                    // let the last snapshots land
            load(`ADDR_SWITCHES);
            for (j = 0; j < hold; j++) begin
                load(`ADDR_BTN_POP);
            end
            load(`ADDR_BTN_EMPTY);
            idle(1);
            if (rsp.data !== 32'd1) begin
                report_mismatch("empty flag after pops", 32'd1, rsp.data);
            end
        end
        end_test();

        begin_test("counters");
        for (i = 0; i < N_CNT_OPS; i++) begin
            pick = $random(seed);
            if (pick[3:0] == 4'd0) begin
                issue(make_req(1'b1, `ADDR_CNT_CLEAR, pick), pick[4]);
            end else if (pick[3:0] < 4'd6) begin
                issue(make_req(1'b0, `ADDR_CYCLE_CNT, 32'h0), pick[4]);
            end else if (pick[3:0] < 4'd11) begin
                issue(make_req(1'b0, `ADDR_INSTR_CNT, 32'h0), pick[4]);
            end else begin
                issue('0, pick[4]);
            end
        end
        idle(1);
        end_test();

        begin_test("unmapped_load");
        for (i = 0; i < N_UNMAPPED; i++) begin
            pick = $random(seed);
            load(32'h4000_0000 | (pick & 32'h0fff_fffc));   // never near 0x8000_00xx
        end
        idle(1);
        end_test();

        $display("summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/periph_pkg.sv
rtl/button_fifo.sv
rtl/board_io_regs.sv
rtl/perf_counters.sv
rtl/load_return.sv
rtl/mmio_hub.sv
verif/tb_mmio_hub.sv

/* Makefile */
all: run

obj_dir/Vtb_mmio_hub: list.f $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
	verilator --binary --assert -Wno-fatal --top-module tb_mmio_hub -f list.f

run: obj_dir/Vtb_mmio_hub
	@out="$$(./obj_dir/Vtb_mmio_hub)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

.PHONY: all run clean
